// ==== flist.f ====
source/fetch_cfg_pkg.sv
source/fetch_bus_pkg.sv
source/line_fill_if.sv
source/fetch_buf_if.sv
source/fetch_ctrl.sv
source/line_fifo.sv
source/read_port.sv
source/fetch_top.sv
test/tb_clk_gen.sv
test/tb_fetch_top.sv

// ==== source/fetch_buf_if.sv ====
`timescale 1ns/1ps

interface fetch_buf_if;

  // write and control strobes from the fetch control
  logic                       push;
  fetch_bus_pkg::line_entry_t push_entry;
  logic                       pop;
  logic                       clear;

  // state of the line buffer
  fetch_bus_pkg::line_entry_t        head;
  logic [fetch_cfg_pkg::PTR_W-1:0]   count;
  logic                              empty;

  modport ctrl (
    output push,
    output push_entry,
    output pop,
    output clear,
    input  head,
    input  count,
    input  empty
  );

  // buffer side
  modport buffer (
    input  push,
    input  push_entry,
    input  pop,
    input  clear,
    output head,
    output count,
    output empty
  );

endinterface

// ==== source/fetch_bus_pkg.sv ====
package fetch_bus_pkg;

  // byte address and line number
  typedef logic [31:0] addr_t;
  typedef logic [fetch_cfg_pkg::TAG_W-1:0] tag_t;

  // whole cache line, word 0 sits in the low bits
  typedef logic [fetch_cfg_pkg::LINE_BYTES*8-1:0] line_t;

  // one instruction word
  typedef logic [31:0] inst_t;

  // read response, zero is okay
  typedef logic [1:0] resp_t;

  // one buffered line
  typedef struct packed {
    tag_t  tag;
    line_t data;
    logic  fault;
  } line_entry_t;

endpackage

// ==== source/fetch_cfg_pkg.sv ====
package fetch_cfg_pkg;

  // cache line geometry
  localparam int LINE_BYTES = 16;
  localparam int OFFSET_W   = 4;
  localparam int TAG_W      = 28;

  // line buffer sizing, pointers carry one extra wrap bit
  localparam int BUF_DEPTH = 2;
  localparam int PTR_W     = 2;

  // first fetch address after reset and its line number
  localparam logic [31:0]      RESET_VEC = 32'h8000_0000;
  localparam logic [TAG_W-1:0] RESET_TAG = TAG_W'(RESET_VEC >> OFFSET_W);

endpackage

// ==== source/fetch_ctrl.sv ====
`timescale 1ns/1ps

module fetch_ctrl (
  input  logic                 clk,
  input  logic                 rst_n,
  input  fetch_bus_pkg::addr_t pc_i,
  input  logic                 flush_i,
  output logic                 inst_valid_o,
  output fetch_bus_pkg::inst_t inst_o,
  output logic                 inst_fault_o,
  line_fill_if.request         fill,
  fetch_buf_if.ctrl            buf_port
);

  fetch_bus_pkg::tag_t pc_tag;
  fetch_bus_pkg::tag_t head_tag;
  fetch_bus_pkg::tag_t next_tag;
  logic [1:0]          word_sel;
  logic                stale;
  logic                outstanding;
  logic                req_d;

  assign pc_tag   = pc_i[31:fetch_cfg_pkg::OFFSET_W];
  assign word_sel = pc_i[fetch_cfg_pkg::OFFSET_W-1:2];
  assign head_tag = buf_port.head.tag;

  // ==========================================================================
  // prefetch request
  // ==========================================================================

  // a read is open from the req strobe until busy drops after the fill
  assign outstanding = fill.busy | fill.req;

  // only one read at a time, and never more lines than the buffer can hold
  assign req_d = ~outstanding & ~flush_i &
                 ((32'(buf_port.count) + 32'(outstanding)) < fetch_cfg_pkg::BUF_DEPTH);

  always_ff @(posedge clk) begin
    if (rst_n) begin
      fill.req <= 1'b0;
    end else begin
      fill.req <= req_d;
    end
  end

  assign fill.req_tag = next_tag;

  // a flush redirects the next line to fetch to the line of the new pc
  always_ff @(posedge clk) begin
    if (rst_n) begin
      next_tag <= fetch_cfg_pkg::RESET_TAG;
    end else if (flush_i) begin
      next_tag <= pc_tag;
    end else if (fill.req) begin
      next_tag <= next_tag + 1'b1;
    end
  end

  // response of a read issued before a flush must not reach the buffer
  always_ff @(posedge clk) begin
    if (rst_n) begin
      stale <= 1'b0;
    end else if (fill.fill) begin
      stale <= 1'b0;
    end else if (flush_i && outstanding) begin
      stale <= 1'b1;
    end
  end

  // ==========================================================================
  // buffer control
  // ==========================================================================

  assign buf_port.clear = flush_i;
  assign buf_port.push  = fill.fill & ~stale & ~flush_i;

  // a live fill always belongs to the line just before next_tag
  assign buf_port.push_entry.tag   = next_tag - 1'b1;
  assign buf_port.push_entry.data  = fill.fill_line;
  assign buf_port.push_entry.fault = |fill.fill_resp;

  // release the head once pc has moved on to the following line
  assign buf_port.pop = ~buf_port.empty & ~flush_i &
                        (fetch_bus_pkg::tag_t'(head_tag + 1'b1) == pc_tag);

  // ==========================================================================
  // fetch stage output
  // ==========================================================================

  assign inst_valid_o = ~buf_port.empty & ~flush_i & (head_tag == pc_tag);
  assign inst_o       = buf_port.head.data[{word_sel, 5'd0} +: 32];
  assign inst_fault_o = buf_port.head.fault;

  // read port has no queue behind it
  a_req_not_busy : assert property (
    @(posedge clk) disable iff (rst_n) fill.req |-> !fill.busy
  );

  // prefetch throttle keeps the buffer from overflowing
  a_push_not_full : assert property (
    @(posedge clk) disable iff (rst_n)
    buf_port.push |-> (32'(buf_port.count) != fetch_cfg_pkg::BUF_DEPTH)
  );

endmodule

// ==== source/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
  input  logic                 clk,
  input  logic                 rst_n,
  // read request channel
  output logic                 ar_valid_o,
  output fetch_bus_pkg::addr_t ar_addr_o,
  input  logic                 ar_ready_i,
  // read data channel
  input  logic                 r_valid_i,
  input  fetch_bus_pkg::line_t r_data_i,
  input  fetch_bus_pkg::resp_t r_resp_i,
  output logic                 r_ready_o,
  // fetch stage
  input  fetch_bus_pkg::addr_t pc_i,
  input  logic                 flush_i,
  output logic                 inst_valid_o,
  output fetch_bus_pkg::inst_t inst_o,
  output logic                 inst_fault_o
);

  line_fill_if u_fill_if ();
  fetch_buf_if u_buf_if ();

  fetch_ctrl i_fetch_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .pc_i         (pc_i),
    .flush_i      (flush_i),
    .inst_valid_o (inst_valid_o),
    .inst_o       (inst_o),
    .inst_fault_o (inst_fault_o),
    .fill         (u_fill_if.request),
    .buf_port     (u_buf_if.ctrl)
  );

  line_fifo #(
    .entry_t (fetch_bus_pkg::line_entry_t)
  ) i_line_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .buf_port (u_buf_if.buffer)
  );

  read_port i_read_port (
    .clk        (clk),
    .rst_n      (rst_n),
    .fill       (u_fill_if.port),
    .ar_valid_o (ar_valid_o),
    .ar_addr_o  (ar_addr_o),
    .ar_ready_i (ar_ready_i),
    .r_valid_i  (r_valid_i),
    .r_data_i   (r_data_i),
    .r_resp_i   (r_resp_i),
    .r_ready_o  (r_ready_o)
  );

endmodule

// ==== source/line_fifo.sv ====
`timescale 1ns/1ps

module line_fifo #(
  parameter type entry_t = fetch_bus_pkg::line_entry_t
) (
  input  logic        clk,
  input  logic        rst_n,
  fetch_buf_if.buffer buf_port
);

  localparam int IDX_W = fetch_cfg_pkg::PTR_W - 1;

  entry_t mem [fetch_cfg_pkg::BUF_DEPTH];

  logic [fetch_cfg_pkg::PTR_W-1:0] wr_ptr;
  logic [fetch_cfg_pkg::PTR_W-1:0] rd_ptr;
  logic                            full;
  logic                            do_push;
  logic                            do_pop;

  // same index with opposite wrap bits means full
  assign full = (wr_ptr == {~rd_ptr[IDX_W], rd_ptr[IDX_W-1:0]});

  assign buf_port.empty = (wr_ptr == rd_ptr);
  assign buf_port.count = wr_ptr - rd_ptr;

  assign do_push = buf_port.push & ~full & ~buf_port.clear;
  assign do_pop  = buf_port.pop & ~buf_port.empty & ~buf_port.clear;

  // pointers, clear wins over push and pop
  always_ff @(posedge clk) begin
    if (rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (buf_port.clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // line storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr[IDX_W-1:0]] <= buf_port.push_entry;
    end
  end

  assign buf_port.head = mem[rd_ptr[IDX_W-1:0]];

  a_no_pop_empty : assert property (
    @(posedge clk) disable iff (rst_n) buf_port.pop |-> !buf_port.empty
  );

endmodule

// ==== source/line_fill_if.sv ====
`timescale 1ns/1ps

interface line_fill_if;

  // one-cycle request strobe plus line number
  logic                req;
  fetch_bus_pkg::tag_t req_tag;

  // read port status and returned line
  logic                 busy;
  logic                 fill;
  fetch_bus_pkg::line_t fill_line;
  fetch_bus_pkg::resp_t fill_resp;

  modport request (
    output req,
    output req_tag,
    input  busy,
    input  fill,
    input  fill_line,
    input  fill_resp
  );

  modport port (
    input  req,
    input  req_tag,
    output busy,
    output fill,
    output fill_line,
    output fill_resp
  );

endinterface

// ==== source/read_port.sv ====
`timescale 1ns/1ps

module read_port (
  input  logic                 clk,
  input  logic                 rst_n,
  line_fill_if.port            fill,
  output logic                 ar_valid_o,
  output fetch_bus_pkg::addr_t ar_addr_o,
  input  logic                 ar_ready_i,
  input  logic                 r_valid_i,
  input  fetch_bus_pkg::line_t r_data_i,
  input  fetch_bus_pkg::resp_t r_resp_i,
  output logic                 r_ready_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA
  } state_t;

  state_t              state;
  fetch_bus_pkg::tag_t tag_q;
  logic                fill_q;

  // ==========================================================================
  // address / data FSM
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state  <= ST_IDLE;
      fill_q <= 1'b0;
    end else begin
      fill_q <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (fill.req) begin
            state <= ST_ADDR;
          end
        end
        ST_ADDR: begin
          if (ar_ready_i) begin
            state <= ST_DATA;
          end
        end
        ST_DATA: begin
          if (r_valid_i) begin
            state  <= ST_IDLE;
            fill_q <= 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // line number of the open request
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && fill.req) begin
      tag_q <= fill.req_tag;
    end
  end

  // returned line and response, handed over one cycle after the handshake
  always_ff @(posedge clk) begin
    if (state == ST_DATA && r_valid_i) begin
      fill.fill_line <= r_data_i;
      fill.fill_resp <= r_resp_i;
    end
  end

  assign ar_valid_o = (state == ST_ADDR);
  assign ar_addr_o  = {tag_q, {fetch_cfg_pkg::OFFSET_W{1'b0}}};
  assign r_ready_o  = (state == ST_DATA);

  // busy also covers the fill cycle itself
  assign fill.fill = fill_q;
  assign fill.busy = (state != ST_IDLE) | fill_q;

  a_addr_stable : assert property (
    @(posedge clk) disable iff (rst_n)
    ar_valid_o && !ar_ready_i |=> $stable(ar_addr_o)
  );

endmodule

// ==== test/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real PERIOD_NS = 10.0
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  always #(PERIOD_NS / 2.0) clk_o = ~clk_o;

endmodule

// ==== test/tb_fetch_top.sv ====
`timescale 1ns/1ps

module tb_fetch_top;

  localparam int          NUM_INST = 3000;
  localparam int          INST_CYC = 40;
  localparam int          RST_CYC  = 5;
  localparam logic [31:0] DATA_KEY = 32'h5a5a_0000;

  logic                 clk;
  logic                 rst_n;
  logic                 ar_valid;
  fetch_bus_pkg::addr_t ar_addr;
  logic                 ar_ready;
  logic                 r_valid;
  fetch_bus_pkg::line_t r_data;
  fetch_bus_pkg::resp_t r_resp;
  logic                 r_ready;
  fetch_bus_pkg::addr_t pc;
  logic                 flush;
  logic                 inst_valid;
  fetch_bus_pkg::inst_t inst;
  logic                 inst_fault;

  integer seed       = 32'hd1689fda;
  int     inst_err   = 0;
  int     fault_err  = 0;
  int     addr_err   = 0;
  int     proto_err  = 0;
  int     prog_err   = 0;
  int     inst_count = 0;
  int     stall      = 0;

  // cache model and request tracking
  logic                 rd_open   = 1'b0;
  fetch_bus_pkg::addr_t rd_addr;
  int                   ar_wait   = -1;
  int                   r_wait    = 0;
  int                   cyc       = 0;
  int                   ar_start  = 0;
  logic                 ar_seen   = 1'b0;
  int                   flush_cyc = -100;
  logic                 redirect  = 1'b0;
  fetch_bus_pkg::addr_t redirect_addr;
  fetch_bus_pkg::addr_t prev_addr = fetch_cfg_pkg::RESET_VEC - 32'd16;

  tb_clk_gen #(.PERIOD_NS(10.0)) i_clk_gen (.clk_o(clk));

  fetch_top i_fetch_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .ar_valid_o   (ar_valid),
    .ar_addr_o    (ar_addr),
    .ar_ready_i   (ar_ready),
    .r_valid_i    (r_valid),
    .r_data_i     (r_data),
    .r_resp_i     (r_resp),
    .r_ready_o    (r_ready),
    .pc_i         (pc),
    .flush_i      (flush),
    .inst_valid_o (inst_valid),
    .inst_o       (inst),
    .inst_fault_o (inst_fault)
  );

  // word k of the line at addr is (addr + 4k) xor the key
  function automatic fetch_bus_pkg::line_t expected_line(input fetch_bus_pkg::addr_t addr);
    fetch_bus_pkg::line_t line;
    int k;
    for (k = 0; k < 4; k++) begin
      line[32*k +: 32] = (addr + 32'(4 * k)) ^ DATA_KEY;
    end
    return line;
  endfunction

  function automatic logic line_has_fault(input fetch_bus_pkg::addr_t addr);
    return (addr[11:8] == 4'hf);
  endfunction

  task automatic check_inst(input fetch_bus_pkg::inst_t got, input fetch_bus_pkg::inst_t exp);
    if (got !== exp) begin
      inst_err++;
      $display("** Error at %0t: inst 0x%08h for pc 0x%08h, expected 0x%08h",
               $time, got, pc, exp);
    end
  endtask

  task automatic check_fault(input logic got, input logic exp);
    if (got !== exp) begin
      fault_err++;
      $display("** Error at %0t: fault %0b for pc 0x%08h, expected %0b", $time, got, pc, exp);
    end
  endtask

  task automatic check_addr(input fetch_bus_pkg::addr_t got, input fetch_bus_pkg::addr_t exp,
                            input string what);
    if (got !== exp) begin
      addr_err++;
      $display("** Error at %0t: %s, addr 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  // ==========================================================================
  // cache model driving both channels on the falling edge
  // ==========================================================================

  always @(negedge clk) begin
    if (rst_n !== 1'b0) begin
      ar_ready = 1'b0;
      r_valid  = 1'b0;
    end else begin
      if (ar_valid === 1'b1 && ar_wait < 0) begin
        ar_wait = $unsigned($random(seed)) % 5;
      end
      ar_ready = (ar_valid === 1'b1 && ar_wait == 0);
      if (ar_wait > 0) begin
        ar_wait--;
      end
      r_valid = 1'b0;
      if (rd_open && r_wait == 0) begin
        r_valid = 1'b1;
        r_data  = expected_line(rd_addr);
        r_resp  = line_has_fault(rd_addr) ? 2'd2 : 2'd0;
      end else if (rd_open) begin
        r_wait--;
      end
    end
  end

  // handshakes seen at the rising edge
  always @(posedge clk) begin
    if (rst_n === 1'b0) begin
      // data ready exactly while a read is open
      if (r_ready !== rd_open) begin
        proto_err++;
        $display("** Error at %0t: r_ready %0b, expected %0b", $time, r_ready, rd_open);
      end
      if (ar_seen && ar_valid !== 1'b1) begin
        proto_err++;
        $display("** Error at %0t: ar_valid dropped before ar_ready", $time);
      end
      if (r_valid && r_ready) begin
        rd_open = 1'b0;
      end
      if (ar_valid && !ar_seen) begin
        ar_seen  = 1'b1;
        ar_start = cyc;
      end
      if (ar_valid && ar_ready) begin
        check_addr(ar_addr, ar_addr & ~32'hf, "request not line aligned");
        // a request already up in or right after the flush cycle predates it
        if (redirect && ar_start > flush_cyc + 1) begin
          check_addr(ar_addr, redirect_addr, "first request after flush");
          redirect = 1'b0;
        end else begin
          check_addr(ar_addr, prev_addr + 32'd16, "sequential request");
        end
        if (rd_open) begin
          proto_err++;
          $display("cache got a second read at %0t while one was still open", $time);
        end
        prev_addr = ar_addr;
        rd_open   = 1'b1;
        rd_addr   = ar_addr;
        r_wait    = $unsigned($random(seed)) % 5;
        ar_wait   = -1;
        ar_seen   = 1'b0;
      end
      if (flush) begin
        flush_cyc     = cyc;
        redirect      = 1'b1;
        redirect_addr = pc & ~32'hf;
      end
      cyc++;
    end
  end

  // ==========================================================================
  // fetch stage stimulus
  // ==========================================================================

  initial begin
    rst_n    = 1'b1;
    pc       = fetch_cfg_pkg::RESET_VEC;
    flush    = 1'b0;
    ar_ready = 1'b0;
    r_valid  = 1'b0;
    r_data   = '0;
    r_resp   = '0;
    repeat (RST_CYC) @(negedge clk);
    rst_n = 1'b0;
    while (inst_count < NUM_INST) begin
      @(negedge clk);
      // sample first, then move pc
      if (inst_valid === 1'b1) begin
        check_inst(inst, pc ^ DATA_KEY);
        check_fault(inst_fault, line_has_fault(pc));
        inst_count++;
        stall = 0;
        if ($unsigned($random(seed)) % 16 == 0) begin
          flush = 1'b1;
          pc    = $random(seed) & ~32'h3;
        end else begin
          flush = 1'b0;
          pc    = pc + 32'd4;
        end
      end else begin
        flush = 1'b0;
        stall++;
        if (stall == INST_CYC) begin
          prog_err++;
          $display("no instruction for %0d cycles at pc 0x%08h, time %0t", stall, pc, $time);
        end
      end
    end
    $display("errors: inst %0d, fault %0d, addr %0d, protocol %0d, progress %0d",
             inst_err, fault_err, addr_err, proto_err, prog_err);
    if (inst_err + fault_err + addr_err + proto_err + prog_err == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // one per-instruction budget for every instruction of the run
  initial begin
    repeat (RST_CYC + NUM_INST * INST_CYC) @(posedge clk);
    $display("run hung: only %0d of %0d instructions after %0d cycles",
             inst_count, NUM_INST, NUM_INST * INST_CYC);
    $display("Verification failed");
    $finish;
  end

endmodule
